//--- mci_pkg.sv
// Shared constants of the MCI register subsystem
// Offsets are byte offsets and must be word aligned
// Only the low MCI_ADDR_W address bits are decoded, so the map aliases above that

package mci_pkg;

    //////////////////////////////
    // Fabric widths
    //////////////////////////////
    localparam int MCI_DATA_W   = 32;               // Fabric data bus
    localparam int MCI_STRB_W   = MCI_DATA_W / 8;   // One strobe per byte
    localparam int MCI_ADDR_W   = 8;                // Decoded byte address
    localparam int MCI_HW_ERR_W = 8;                // HW error sources per class

    //////////////////////////////
    // Constants and reset values
    //////////////////////////////
    localparam logic [31:0] MCI_CAPABILITIES    = 32'h0000_0003;
    localparam logic [31:0] MCI_HW_REV_ID       = 32'h0000_1000;
    localparam logic [31:0] MCI_WDT_TIMEOUT_RST = 32'h0000_0100;   // Cycles to expiry

    //////////////////////////////
    // Register map
    //////////////////////////////
    localparam logic [7:0] MCI_OFS_CAPABILITIES        = 8'h00;   // RO
    localparam logic [7:0] MCI_OFS_HW_REV_ID           = 8'h04;   // RO
    localparam logic [7:0] MCI_OFS_FLOW_STATUS         = 8'h08;
    localparam logic [7:0] MCI_OFS_RESET_REASON        = 8'h0C;
    localparam logic [7:0] MCI_OFS_HW_ERROR_FATAL      = 8'h10;   // W1C
    localparam logic [7:0] MCI_OFS_HW_ERROR_NON_FATAL  = 8'h14;   // W1C
    localparam logic [7:0] MCI_OFS_FW_ERROR_FATAL      = 8'h18;
    localparam logic [7:0] MCI_OFS_FW_ERROR_NON_FATAL  = 8'h1C;
    localparam logic [7:0] MCI_OFS_WDT_CTRL            = 8'h20;   // Bit 0 enable
    localparam logic [7:0] MCI_OFS_WDT_TIMEOUT         = 8'h24;
    localparam logic [7:0] MCI_OFS_WDT_STATUS          = 8'h28;   // Bit 0 expired, W1C
    localparam logic [7:0] MCI_OFS_MTIME_L             = 8'h2C;
    localparam logic [7:0] MCI_OFS_MTIME_H             = 8'h30;
    localparam logic [7:0] MCI_OFS_GENERIC_INPUT_WIRES = 8'h34;   // RO

endpackage

//--- mci_wdt.sv
// Watchdog. Counts while enabled and not expired
// Expiry is sticky until cleared; the clear also restarts the count
// A timeout of 0 wraps the full 32 bit range before expiring

`timescale 1ns/100ps

module mci_wdt (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        wdt_enable,
    input  logic [31:0] wdt_timeout,
    input  logic        wdt_clear,     // One-cycle W1C pulse
    output logic        wdt_expired
);

    logic [31:0] wdt_cnt;
    logic        wdt_hit;

    // Last count before expiry
    assign wdt_hit = (wdt_cnt == wdt_timeout - 32'd1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wdt_cnt     <= '0;
            wdt_expired <= 1'b0;
        end else if (wdt_clear) begin
            wdt_cnt     <= '0;        // Clear restarts the count
            wdt_expired <= 1'b0;
        end else if (!wdt_enable) begin
            wdt_cnt     <= '0;        // Disabled, hold at zero
        end else if (!wdt_expired) begin
            wdt_cnt <= wdt_cnt + 32'd1;
            if (wdt_hit) begin
                wdt_expired <= 1'b1;  // Lands timeout edges after enable
            end
        end
    end

endmodule

//--- mci_mtime.sv
// 64 bit machine timer, increments every cycle
// A load writes the enabled bits of one half and skips that edge's increment
// Loads of both halves in one cycle cannot occur, one address per request

`timescale 1ns/100ps

module mci_mtime (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        mtime_load_lo,
    input  logic        mtime_load_hi,
    input  logic [31:0] wr_data,      // Already masked by strobes
    input  logic [31:0] wr_biten,
    output logic [63:0] mtime
);

    logic [63:0] mtime_nxt;
    logic [31:0] lo_load;
    logic [31:0] hi_load;

    assign lo_load = (mtime[31:0]  & ~wr_biten) | (wr_data & wr_biten);
    assign hi_load = (mtime[63:32] & ~wr_biten) | (wr_data & wr_biten);

    always_comb begin
        mtime_nxt = mtime + 64'd1;   // Free running
        if (mtime_load_lo) begin
            mtime_nxt = {mtime[63:32], lo_load};
        end
        if (mtime_load_hi) begin
            mtime_nxt = {hi_load, mtime[31:0]};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mtime <= '0;
        end else begin
            mtime <= mtime_nxt;
        end
    end

endmodule

//--- mci_err.sv
// Sticky hardware error status, set on rising input edges, W1C from firmware
// Set wins over a clear in the same cycle
// Summary outputs are registered, one cycle behind their sources

`timescale 1ns/100ps

module mci_err (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic [mci_pkg::MCI_HW_ERR_W-1:0] hw_error_fatal,
    input  logic [mci_pkg::MCI_HW_ERR_W-1:0] hw_error_non_fatal,
    input  logic                             clr_fatal,
    input  logic                             clr_non_fatal,
    input  logic [31:0]                      wr_data,   // W1C mask, strobed
    input  logic [31:0]                      fw_error_fatal,
    input  logic [31:0]                      fw_error_non_fatal,
    input  logic                             wdt_expired,
    output logic [mci_pkg::MCI_HW_ERR_W-1:0] hw_error_fatal_sts,
    output logic [mci_pkg::MCI_HW_ERR_W-1:0] hw_error_non_fatal_sts,
    output logic                             error_fatal,
    output logic                             error_non_fatal
);

    import mci_pkg::*;

    logic [MCI_HW_ERR_W-1:0] fatal_q;       // Input history for edge detect
    logic [MCI_HW_ERR_W-1:0] non_fatal_q;
    logic [MCI_HW_ERR_W-1:0] fatal_clr;
    logic [MCI_HW_ERR_W-1:0] non_fatal_clr;

    assign fatal_clr     = clr_fatal     ? wr_data[MCI_HW_ERR_W-1:0] : '0;
    assign non_fatal_clr = clr_non_fatal ? wr_data[MCI_HW_ERR_W-1:0] : '0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fatal_q                <= '0;
            non_fatal_q            <= '0;
            hw_error_fatal_sts     <= '0;
            hw_error_non_fatal_sts <= '0;
            error_fatal            <= 1'b0;
            error_non_fatal        <= 1'b0;
        end else begin
            fatal_q     <= hw_error_fatal;
            non_fatal_q <= hw_error_non_fatal;
            // Clear first, rising edge ORed on top
            hw_error_fatal_sts     <= (hw_error_fatal_sts & ~fatal_clr)
                                    | (hw_error_fatal & ~fatal_q);
            hw_error_non_fatal_sts <= (hw_error_non_fatal_sts & ~non_fatal_clr)
                                    | (hw_error_non_fatal & ~non_fatal_q);
            error_fatal     <= (|hw_error_fatal_sts) | (|fw_error_fatal) | wdt_expired;
            error_non_fatal <= (|hw_error_non_fatal_sts) | (|fw_error_non_fatal);
        end
    end

endmodule

//--- mci_reg.sv
// CSR block of the MCI. Requests answer in the same cycle, no stall
// Writes land at the edge closing the request cycle, masked by byte strobes
// An erroring access changes no state
// Timer and error state live in their own blocks; only strobes go out from here

`timescale 1ns/100ps

module mci_reg (
    input  logic                           clk,
    input  logic                           arst_n,

    // Fabric port
    input  logic                           req_dv,
    input  logic                           req_write,
    input  logic [mci_pkg::MCI_ADDR_W-1:0] req_addr,
    input  logic [mci_pkg::MCI_DATA_W-1:0] req_wdata,
    input  logic [mci_pkg::MCI_STRB_W-1:0] req_wstrb,
    output logic [mci_pkg::MCI_DATA_W-1:0] rdata,
    output logic                           error,

    // Status from steered blocks
    input  logic [31:0]                      generic_input_wires,
    input  logic                             wdt_expired,
    input  logic [63:0]                      mtime,
    input  logic [mci_pkg::MCI_HW_ERR_W-1:0] hw_error_fatal_sts,
    input  logic [mci_pkg::MCI_HW_ERR_W-1:0] hw_error_non_fatal_sts,

    // RW register contents
    output logic [31:0]                    flow_status,
    output logic [31:0]                    fw_error_fatal,
    output logic [31:0]                    fw_error_non_fatal,
    output logic                           wdt_enable,
    output logic [31:0]                    wdt_timeout,

    // One-cycle strobes with masked write data
    output logic                           wdt_clear,
    output logic                           mtime_load_lo,
    output logic                           mtime_load_hi,
    output logic                           clr_fatal,
    output logic                           clr_non_fatal,
    output logic [31:0]                    wr_data,
    output logic [31:0]                    wr_biten
);

    import mci_pkg::*;

    logic [31:0] reset_reason;
    logic [31:0] rd_mux;
    logic        mapped;       // Offset hits the map
    logic        read_only;    // Target is not writable
    logic        addr_err;
    logic        wr_en;        // Valid, error free write

    // Old value merged with the strobed bytes
    function automatic logic [31:0] merge(input logic [31:0] old_val,
                                          input logic [31:0] new_val,
                                          input logic [31:0] biten);
        return (old_val & ~biten) | (new_val & biten);
    endfunction

    //////////////////////////////
    // Strobes to bit enables
    //////////////////////////////
    genvar i;
    generate
        for (i = 0; i < MCI_DATA_W; i++) begin : g_biten
            assign wr_biten[i] = req_wstrb[i/8];
        end
    endgenerate

    assign wr_data = req_wdata & wr_biten;   // Unstrobed bits read as 0 downstream

    //////////////////////////////
    // Decode and read mux
    //////////////////////////////
    always_comb begin
        rd_mux    = '0;
        mapped    = 1'b1;
        read_only = 1'b0;
        case (req_addr)
            MCI_OFS_CAPABILITIES: begin
                rd_mux    = MCI_CAPABILITIES;
                read_only = 1'b1;
            end
            MCI_OFS_HW_REV_ID: begin
                rd_mux    = MCI_HW_REV_ID;
                read_only = 1'b1;
            end
            MCI_OFS_FLOW_STATUS:        rd_mux = flow_status;
            MCI_OFS_RESET_REASON:       rd_mux = reset_reason;
            MCI_OFS_HW_ERROR_FATAL:     rd_mux = 32'(hw_error_fatal_sts);   // Zero extended
            MCI_OFS_HW_ERROR_NON_FATAL: rd_mux = 32'(hw_error_non_fatal_sts);
            MCI_OFS_FW_ERROR_FATAL:     rd_mux = fw_error_fatal;
            MCI_OFS_FW_ERROR_NON_FATAL: rd_mux = fw_error_non_fatal;
            MCI_OFS_WDT_CTRL:           rd_mux = {31'b0, wdt_enable};
            MCI_OFS_WDT_TIMEOUT:        rd_mux = wdt_timeout;
            MCI_OFS_WDT_STATUS:         rd_mux = {31'b0, wdt_expired};
            MCI_OFS_MTIME_L:            rd_mux = mtime[31:0];
            MCI_OFS_MTIME_H:            rd_mux = mtime[63:32];
            MCI_OFS_GENERIC_INPUT_WIRES: begin
                rd_mux    = generic_input_wires;
                read_only = 1'b1;
            end
            default:                    mapped = 1'b0;
        endcase
    end

    // Outside the map; unaligned offsets miss it too
    assign addr_err = ~mapped;

    assign error = req_dv & (addr_err | (req_write & read_only));
    assign rdata = (req_dv & ~req_write & ~error) ? rd_mux : '0;
    assign wr_en = req_dv & req_write & ~error;

    //////////////////////////////
    // Strobes to other blocks
    //////////////////////////////
    assign wdt_clear     = wr_en & (req_addr == MCI_OFS_WDT_STATUS) & wr_data[0];
    assign mtime_load_lo = wr_en & (req_addr == MCI_OFS_MTIME_L);
    assign mtime_load_hi = wr_en & (req_addr == MCI_OFS_MTIME_H);
    assign clr_fatal     = wr_en & (req_addr == MCI_OFS_HW_ERROR_FATAL);
    assign clr_non_fatal = wr_en & (req_addr == MCI_OFS_HW_ERROR_NON_FATAL);

    //////////////////////////////
    // RW registers
    //////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flow_status        <= '0;
            reset_reason       <= '0;
            fw_error_fatal     <= '0;
            fw_error_non_fatal <= '0;
            wdt_enable         <= 1'b0;
            wdt_timeout        <= MCI_WDT_TIMEOUT_RST;
        end else if (wr_en) begin
            case (req_addr)
                MCI_OFS_FLOW_STATUS:
                    flow_status <= merge(flow_status, req_wdata, wr_biten);
                MCI_OFS_RESET_REASON:
                    reset_reason <= merge(reset_reason, req_wdata, wr_biten);
                MCI_OFS_FW_ERROR_FATAL:
                    fw_error_fatal <= merge(fw_error_fatal, req_wdata, wr_biten);
                MCI_OFS_FW_ERROR_NON_FATAL:
                    fw_error_non_fatal <= merge(fw_error_non_fatal, req_wdata, wr_biten);
                MCI_OFS_WDT_CTRL:
                    if (wr_biten[0]) wdt_enable <= req_wdata[0];   // Upper bits reserved
                MCI_OFS_WDT_TIMEOUT:
                    wdt_timeout <= merge(wdt_timeout, req_wdata, wr_biten);
                default: ;   // W1C and timer targets handled by strobes
            endcase
        end
    end

endmodule

//--- mci_top.sv
// MCI register subsystem top. CSR block with watchdog, timer and error collector
// hold is always low: every access completes in its request cycle
// All logic on clk, asynchronous reset arst_n

`timescale 1ns/100ps

module mci_top (
    input  logic                             clk,
    input  logic                             arst_n,

    // Fabric port
    input  logic                             req_dv,
    input  logic                             req_write,
    input  logic [mci_pkg::MCI_ADDR_W-1:0]   req_addr,
    input  logic [mci_pkg::MCI_DATA_W-1:0]   req_wdata,
    input  logic [mci_pkg::MCI_STRB_W-1:0]   req_wstrb,
    output logic [mci_pkg::MCI_DATA_W-1:0]   rdata,
    output logic                             error,
    output logic                             hold,

    // SoC side
    input  logic [31:0]                      generic_input_wires,
    input  logic [mci_pkg::MCI_HW_ERR_W-1:0] hw_error_fatal,
    input  logic [mci_pkg::MCI_HW_ERR_W-1:0] hw_error_non_fatal,
    output logic [31:0]                      flow_status,
    output logic [63:0]                      mtime,
    output logic                             error_fatal,
    output logic                             error_non_fatal
);

    import mci_pkg::*;

    // CSR block to steered blocks
    logic                    wdt_enable;
    logic [31:0]             wdt_timeout;
    logic                    wdt_clear;
    logic                    wdt_expired;
    logic                    mtime_load_lo;
    logic                    mtime_load_hi;
    logic                    clr_fatal;
    logic                    clr_non_fatal;
    logic [31:0]             wr_data;
    logic [31:0]             wr_biten;
    logic [31:0]             fw_error_fatal;
    logic [31:0]             fw_error_non_fatal;
    logic [MCI_HW_ERR_W-1:0] hw_error_fatal_sts;
    logic [MCI_HW_ERR_W-1:0] hw_error_non_fatal_sts;

    assign hold = 1'b0;   // Single cycle access

    //////////////////////////////
    // CSR block
    //////////////////////////////
    mci_reg u_reg (
        .clk                    (clk),
        .arst_n                 (arst_n),
        .req_dv                 (req_dv),
        .req_write              (req_write),
        .req_addr               (req_addr),
        .req_wdata              (req_wdata),
        .req_wstrb              (req_wstrb),
        .rdata                  (rdata),
        .error                  (error),
        .generic_input_wires    (generic_input_wires),
        .wdt_expired            (wdt_expired),
        .mtime                  (mtime),
        .hw_error_fatal_sts     (hw_error_fatal_sts),
        .hw_error_non_fatal_sts (hw_error_non_fatal_sts),
        .flow_status            (flow_status),
        .fw_error_fatal         (fw_error_fatal),
        .fw_error_non_fatal     (fw_error_non_fatal),
        .wdt_enable             (wdt_enable),
        .wdt_timeout            (wdt_timeout),
        .wdt_clear              (wdt_clear),
        .mtime_load_lo          (mtime_load_lo),
        .mtime_load_hi          (mtime_load_hi),
        .clr_fatal              (clr_fatal),
        .clr_non_fatal          (clr_non_fatal),
        .wr_data                (wr_data),
        .wr_biten               (wr_biten)
    );

    //////////////////////////////
    // Steered blocks
    //////////////////////////////
    mci_wdt u_wdt (
        .clk         (clk),
        .arst_n      (arst_n),
        .wdt_enable  (wdt_enable),
        .wdt_timeout (wdt_timeout),
        .wdt_clear   (wdt_clear),
        .wdt_expired (wdt_expired)
    );

    mci_mtime u_mtime (
        .clk           (clk),
        .arst_n        (arst_n),
        .mtime_load_lo (mtime_load_lo),
        .mtime_load_hi (mtime_load_hi),
        .wr_data       (wr_data),
        .wr_biten      (wr_biten),
        .mtime         (mtime)
    );

    mci_err u_err (
        .clk                    (clk),
        .arst_n                 (arst_n),
        .hw_error_fatal         (hw_error_fatal),
        .hw_error_non_fatal     (hw_error_non_fatal),
        .clr_fatal              (clr_fatal),
        .clr_non_fatal          (clr_non_fatal),
        .wr_data                (wr_data),
        .fw_error_fatal         (fw_error_fatal),
        .fw_error_non_fatal     (fw_error_non_fatal),
        .wdt_expired            (wdt_expired),      // Watchdog counts as fatal
        .hw_error_fatal_sts     (hw_error_fatal_sts),
        .hw_error_non_fatal_sts (hw_error_non_fatal_sts),
        .error_fatal            (error_fatal),
        .error_non_fatal        (error_non_fatal)
    );

endmodule

//--- tb_mci.sv
// Directed testbench for mci_top
// Requests are driven on the falling edge, responses sampled a quarter period later
// Request tasks start and end on a falling edge, so back to back calls give
// back to back request cycles; watchdog and timer checks count on that

`timescale 1ns/100ps

module tb_mci;

    import mci_pkg::*;

    localparam int          CLK_PERIOD = 20;
    localparam int          MAX_CYCLES = 5000;        // Whole run needs a few hundred
    localparam int          MTIME_IDLE = 16;          // Idle cycles before timer read
    localparam logic [31:0] GPIO_VAL   = 32'h5a3c_96e1;

    logic                    clk;
    logic                    arst_n;
    logic                    req_dv;
    logic                    req_write;
    logic [MCI_ADDR_W-1:0]   req_addr;
    logic [MCI_DATA_W-1:0]   req_wdata;
    logic [MCI_STRB_W-1:0]   req_wstrb;
    logic [MCI_DATA_W-1:0]   rdata;
    logic                    error;
    logic                    hold;
    logic [31:0]             generic_input_wires;
    logic [MCI_HW_ERR_W-1:0] hw_error_fatal;
    logic [MCI_HW_ERR_W-1:0] hw_error_non_fatal;
    logic [31:0]             flow_status;
    logic [63:0]             mtime;
    logic                    error_fatal;
    logic                    error_non_fatal;

    int          err_count = 0;
    int          chk_count = 0;
    int          cycles    = 0;
    integer      seed;
    logic [31:0] flow_exp;                               // Expected FLOW_STATUS

    mci_top DUT (
        .clk                 (clk),
        .arst_n              (arst_n),
        .req_dv              (req_dv),
        .req_write           (req_write),
        .req_addr            (req_addr),
        .req_wdata           (req_wdata),
        .req_wstrb           (req_wstrb),
        .rdata               (rdata),
        .error               (error),
        .hold                (hold),
        .generic_input_wires (generic_input_wires),
        .hw_error_fatal      (hw_error_fatal),
        .hw_error_non_fatal  (hw_error_non_fatal),
        .flow_status         (flow_status),
        .mtime               (mtime),
        .error_fatal         (error_fatal),
        .error_non_fatal     (error_non_fatal)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // Run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, run stopped", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    //////////////////////////////
    // Compare tasks
    //////////////////////////////
    task automatic check_data(input string name, input logic [MCI_DATA_W-1:0] got,
                              input logic [MCI_DATA_W-1:0] exp);
        chk_count++;
        if (got !== exp) begin
            err_count++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        chk_count++;
        if (got !== exp) begin
            err_count++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_mtime(input string name, input logic [63:0] got,
                               input logic [63:0] lo, input logic [63:0] hi);
        chk_count++;
        if (got < lo || got > hi) begin
            err_count++;
            $display("CHECK FAILED %s: got %h, expected %h to %h", name, got, lo, hi);
        end
    endtask

    //////////////////////////////
    // Fabric requests
    //////////////////////////////
    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic bus_write(input logic [MCI_ADDR_W-1:0] addr,
                             input logic [MCI_DATA_W-1:0] data,
                             input logic [MCI_STRB_W-1:0] strb, output logic err);
        req_dv    = 1'b1;
        req_write = 1'b1;
        req_addr  = addr;
        req_wdata = data;
        req_wstrb = strb;
        #(CLK_PERIOD/4);
        err = error;                                     // Settled, edge still ahead
        @(negedge clk);
        req_dv    = 1'b0;
        req_write = 1'b0;
        req_wstrb = '0;
    endtask

    task automatic bus_read(input logic [MCI_ADDR_W-1:0] addr,
                            output logic [MCI_DATA_W-1:0] data, output logic err);
        req_dv    = 1'b1;
        req_write = 1'b0;
        req_addr  = addr;
        #(CLK_PERIOD/4);
        data = rdata;
        err  = error;
        @(negedge clk);
        req_dv = 1'b0;
    endtask

    task automatic write_ok(input logic [MCI_ADDR_W-1:0] addr,
                            input logic [MCI_DATA_W-1:0] data,
                            input logic [MCI_STRB_W-1:0] strb);
        logic err;
        bus_write(addr, data, strb, err);
        check_bit("error", err, 1'b0);
    endtask

    task automatic read_expect(input string name, input logic [MCI_ADDR_W-1:0] addr,
                               input logic [MCI_DATA_W-1:0] exp);
        logic [MCI_DATA_W-1:0] rd;
        logic                  err;
        bus_read(addr, rd, err);
        check_bit("error", err, 1'b0);
        check_data(name, rd, exp);
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////
    task automatic test_reset();
        read_expect("CAPABILITIES", MCI_OFS_CAPABILITIES, MCI_CAPABILITIES);
        read_expect("HW_REV_ID", MCI_OFS_HW_REV_ID, MCI_HW_REV_ID);
        read_expect("FLOW_STATUS", MCI_OFS_FLOW_STATUS, 32'h0);
        read_expect("RESET_REASON", MCI_OFS_RESET_REASON, 32'h0);
        read_expect("HW_ERROR_FATAL", MCI_OFS_HW_ERROR_FATAL, 32'h0);
        read_expect("HW_ERROR_NON_FATAL", MCI_OFS_HW_ERROR_NON_FATAL, 32'h0);
        read_expect("FW_ERROR_FATAL", MCI_OFS_FW_ERROR_FATAL, 32'h0);
        read_expect("FW_ERROR_NON_FATAL", MCI_OFS_FW_ERROR_NON_FATAL, 32'h0);
        read_expect("WDT_CTRL", MCI_OFS_WDT_CTRL, 32'h0);
        read_expect("WDT_TIMEOUT", MCI_OFS_WDT_TIMEOUT, MCI_WDT_TIMEOUT_RST);
        read_expect("WDT_STATUS", MCI_OFS_WDT_STATUS, 32'h0);
        read_expect("MTIME_H", MCI_OFS_MTIME_H, 32'h0);        // Low half still counting
        read_expect("GENERIC_INPUT_WIRES", MCI_OFS_GENERIC_INPUT_WIRES, GPIO_VAL);
        check_bit("error_fatal", error_fatal, 1'b0);
        check_bit("error_non_fatal", error_non_fatal, 1'b0);
        check_bit("hold", hold, 1'b0);
    endtask

    // Single and mixed strobes, expected value merged byte by byte
    task automatic test_strobes();
        logic [MCI_STRB_W-1:0] strb_list [10];
        logic [MCI_DATA_W-1:0] data;
        strb_list = '{4'h1, 4'h2, 4'h4, 4'h8, 4'h5, 4'ha, 4'h3, 4'hc, 4'h6, 4'hf};
        flow_exp  = '0;
        foreach (strb_list[k]) begin
            data = $random(seed);
            write_ok(MCI_OFS_FLOW_STATUS, data, strb_list[k]);
            for (int b = 0; b < MCI_STRB_W; b++) begin
                if (strb_list[k][b]) flow_exp[b*8 +: 8] = data[b*8 +: 8];
            end
            read_expect("FLOW_STATUS", MCI_OFS_FLOW_STATUS, flow_exp);
            check_data("flow_status", flow_status, flow_exp);
        end
    endtask

    task automatic test_errors();
        logic [MCI_DATA_W-1:0] rd;
        logic                  err;
        bus_write(8'h38, 32'hdead_beef, 4'hf, err);        // Past the map
        check_bit("error", err, 1'b1);
        bus_read(8'hfc, rd, err);
        check_bit("error", err, 1'b1);
        check_data("rdata", rd, '0);                        // No valid read
        bus_write(MCI_OFS_FLOW_STATUS + 8'd1, ~flow_exp, 4'hf, err);
        check_bit("error", err, 1'b1);
        read_expect("FLOW_STATUS", MCI_OFS_FLOW_STATUS, flow_exp);
        bus_read(MCI_OFS_WDT_TIMEOUT + 8'd2, rd, err);
        check_bit("error", err, 1'b1);
        bus_write(MCI_OFS_CAPABILITIES, ~MCI_CAPABILITIES, 4'hf, err);   // RO target
        check_bit("error", err, 1'b1);
        read_expect("CAPABILITIES", MCI_OFS_CAPABILITIES, MCI_CAPABILITIES);
    endtask

    // One HW error class: pulse a pin, W1C another bit, then the set bit
    task automatic hw_error_class(input logic fatal);
        logic [MCI_ADDR_W-1:0]   ofs;
        logic [MCI_HW_ERR_W-1:0] pin;
        string                   reg_name;
        string                   out_name;
        ofs      = fatal ? MCI_OFS_HW_ERROR_FATAL : MCI_OFS_HW_ERROR_NON_FATAL;
        pin      = fatal ? 8'h08 : 8'h20;
        reg_name = fatal ? "HW_ERROR_FATAL" : "HW_ERROR_NON_FATAL";
        out_name = fatal ? "error_fatal" : "error_non_fatal";
        if (fatal) hw_error_fatal = pin;
        else       hw_error_non_fatal = pin;
        idle(1);                                         // Sticky bit set here
        hw_error_fatal     = '0;
        hw_error_non_fatal = '0;
        idle(1);                                         // Summary one edge later
        check_bit(out_name, fatal ? error_fatal : error_non_fatal, 1'b1);
        read_expect(reg_name, ofs, 32'(pin));
        write_ok(ofs, 32'h1, 4'hf);
        read_expect(reg_name, ofs, 32'(pin));
        check_bit(out_name, fatal ? error_fatal : error_non_fatal, 1'b1);
        write_ok(ofs, 32'(pin), 4'hf);
        read_expect(reg_name, ofs, 32'h0);
        check_bit(out_name, fatal ? error_fatal : error_non_fatal, 1'b0);
    endtask

    task automatic test_fw_non_fatal();
        write_ok(MCI_OFS_FW_ERROR_NON_FATAL, 32'h0000_0100, 4'hf);
        idle(1);
        check_bit("error_non_fatal", error_non_fatal, 1'b1);
        read_expect("FW_ERROR_NON_FATAL", MCI_OFS_FW_ERROR_NON_FATAL, 32'h0000_0100);
        write_ok(MCI_OFS_FW_ERROR_NON_FATAL, 32'h0, 4'hf);
        idle(1);
        check_bit("error_non_fatal", error_non_fatal, 1'b0);
    endtask

    task automatic test_watchdog();
        logic [MCI_DATA_W-1:0] rd;
        logic                  err;
        int                    n;
        write_ok(MCI_OFS_WDT_TIMEOUT, 32'd20, 4'hf);
        write_ok(MCI_OFS_WDT_CTRL, 32'h1, 4'hf);          // Cycle 0
        idle(9);
        read_expect("WDT_STATUS", MCI_OFS_WDT_STATUS, 32'h0);   // Cycle 10
        check_bit("error_fatal", error_fatal, 1'b0);
        n  = 11;
        rd = '0;
        while (rd[0] !== 1'b1 && n <= 25) begin
            bus_read(MCI_OFS_WDT_STATUS, rd, err);
            check_bit("error", err, 1'b0);
            n++;
        end
        if (rd[0] !== 1'b1) begin
            err_count++;
            $display("Watchdog did not expire by cycle 25");
        end
        check_bit("error_fatal", error_fatal, 1'b1);
        write_ok(MCI_OFS_WDT_CTRL, 32'h0, 4'hf);
        write_ok(MCI_OFS_WDT_STATUS, 32'h1, 4'hf);        // W1C expiry
        read_expect("WDT_STATUS", MCI_OFS_WDT_STATUS, 32'h0);
        idle(2);
        check_bit("error_fatal", error_fatal, 1'b0);
    endtask

    task automatic test_mtime();
        logic [63:0]           load;
        logic [MCI_DATA_W-1:0] lo_rd;
        logic [MCI_DATA_W-1:0] hi_rd;
        logic                  err;
        load = 64'h0000_0012_ffff_ff00;                  // No carry within the test
        write_ok(MCI_OFS_MTIME_H, load[63:32], 4'hf);
        write_ok(MCI_OFS_MTIME_L, load[31:0], 4'hf);
        idle(MTIME_IDLE);
        bus_read(MCI_OFS_MTIME_L, lo_rd, err);
        check_bit("error", err, 1'b0);
        bus_read(MCI_OFS_MTIME_H, hi_rd, err);
        check_bit("error", err, 1'b0);
        check_mtime("MTIME", {hi_rd, lo_rd}, load + 64'(MTIME_IDLE),
                    load + 64'(MTIME_IDLE + 4));
        // Port sampled two request cycles after the MTIME_L read
        check_mtime("mtime", mtime, load + 64'(MTIME_IDLE + 2),
                    load + 64'(MTIME_IDLE + 6));
        // Byte 1 only, rest of the high half kept
        write_ok(MCI_OFS_MTIME_H, 32'h0000_5600, 4'h2);
        read_expect("MTIME_H", MCI_OFS_MTIME_H, 32'h0000_5612);
    endtask

    //////////////////////////////
    // Sequence
    //////////////////////////////
    initial begin
        seed                = 32'hd57f;
        arst_n              = 1'b0;
        req_dv              = 1'b0;
        req_write           = 1'b0;
        req_addr            = '0;
        req_wdata           = '0;
        req_wstrb           = '0;
        generic_input_wires = GPIO_VAL;
        hw_error_fatal      = '0;
        hw_error_non_fatal  = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        test_reset();
        test_strobes();
        test_errors();
        hw_error_class(1'b1);
        hw_error_class(1'b0);
        test_fw_non_fatal();
        test_watchdog();
        test_mtime();
        idle(2);
        $display("Checks: %0d, errors: %0d", chk_count, err_count);
        if (err_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
mci_pkg.sv
mci_wdt.sv
mci_mtime.sv
mci_err.sv
mci_reg.sv
mci_top.sv
tb_mci.sv

//--- run.sh
#!/bin/sh
# Build and run the MCI testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f list.f --top-module tb_mci -o sim_mci
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_mci > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Test OK$" sim.log; then
    echo "PASS"
    exit 0
fi

echo "FAIL: pass message not found in sim.log"
exit 1
